// File: hw/qspi_pkg.sv
//----------------------------------------
// QSPI SRAM bridge shared definitions
// Widths, SRAM command bytes, sequencer
// states and frame step counts
//----------------------------------------
package qspi_pkg;

    // Bus and serial widths
    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int sio_w  = 4;
    localparam int seq_w  = 4;

    // SRAM command bytes
    localparam logic [data_w-1:0] cmd_eqio  = 8'h38;
    localparam logic [data_w-1:0] cmd_read  = 8'h03;
    localparam logic [data_w-1:0] cmd_write = 8'h02;

    // Last step of each frame
    localparam logic [seq_w-1:0] seq_init_last  = 4'd8;
    localparam logic [seq_w-1:0] seq_write_last = 4'd8;
    localparam logic [seq_w-1:0] seq_read_last  = 4'd11;

    typedef enum logic [2:0] {
        st_startup,
        st_init,
        st_idle,
        st_read,
        st_write
    } state_t;

    // Byte to load into the transmit shifter
    typedef enum logic [2:0] {
        ld_none,
        ld_eqio,
        ld_rdcmd,
        ld_wrcmd,
        ld_addr_hi,
        ld_addr_lo,
        ld_wdata
    } txd_load_t;

endpackage

// File: hw/qspi_bus_port.sv
//----------------------------------------
// QSPI SRAM bridge bus port
// Accepts byte requests, holds address and
// write data, keeps the ready flag
//----------------------------------------
`timescale 1ns/1ps

module qspi_bus_port
(
    input  logic                          CLK,
    input  logic                          RES,
    input  logic                          bus_req,
    input  logic                          bus_write,
    input  logic [qspi_pkg::addr_w-1:0]   bus_addr,
    input  logic [qspi_pkg::data_w-1:0]   bus_wdata,
    output logic [qspi_pkg::data_w-1:0]   bus_rdata,
    output logic                          bus_rdy,
    input  logic                          rdy_set,
    input  logic                          rdy_clr,
    input  logic [qspi_pkg::data_w-1:0]   rdata,
    output logic                          accept_read,
    output logic                          accept_write,
    output logic [qspi_pkg::addr_w-1:0]   addr,
    output logic [qspi_pkg::data_w-1:0]   wdata
);

    // Request taken only while ready
    assign accept_read  = bus_req & ~bus_write & bus_rdy;
    assign accept_write = bus_req &  bus_write & bus_rdy;

    always_ff @(posedge CLK)
    begin
        if (accept_read | accept_write)
            addr <= bus_addr;
    end

    always_ff @(posedge CLK)
    begin
        if (accept_write)
            wdata <= bus_wdata;
    end

    // Ready flag, clear wins over set
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            bus_rdy <= 1'b0;
        else if (rdy_clr)
            bus_rdy <= 1'b0;
        else if (rdy_set)
            bus_rdy <= 1'b1;
    end

    assign bus_rdata = rdata;

endmodule

// File: hw/qspi_sequencer.sv
//----------------------------------------
// QSPI SRAM bridge sequencer
// Steps through init, write and read
// frames and strobes the phy controls
//----------------------------------------
`timescale 1ns/1ps

module qspi_sequencer
(
    input  logic                        CLK,
    input  logic                        RES,
    input  logic                        accept_read,
    input  logic                        accept_write,
    output logic                        rdy_set,
    output logic                        rdy_clr,
    output logic                        cs_assert,
    output logic                        cs_negate,
    output logic                        sck_on,
    output logic                        sck_off,
    output qspi_pkg::txd_load_t         txd_load,
    output logic                        shift_1,
    output logic                        shift_4,
    output logic [qspi_pkg::sio_w-1:0]  sio_e_set,
    output logic [qspi_pkg::sio_w-1:0]  sio_e_clr,
    output logic                        rx_hi,
    output logic                        rx_lo
);
    import qspi_pkg::*;

    state_t           state;
    state_t           state_next;
    logic [seq_w-1:0] seq;
    logic             seq_inc;
    logic             frame_end;
    logic             restart;

    // Counter runs while a frame is active, otherwise it clears
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
        begin
            state <= st_startup;
            seq   <= '0;
        end
        else
        begin
            state <= state_next;
            seq   <= seq_inc ? seq + 1'b1 : '0;
        end
    end

    always_comb
    begin
        state_next = state;
        seq_inc    = 1'b0;
        frame_end  = 1'b0;
        restart    = 1'b0;
        rdy_set    = 1'b0;
        rdy_clr    = 1'b0;
        cs_assert  = 1'b0;
        cs_negate  = 1'b0;
        sck_on     = 1'b0;
        sck_off    = 1'b0;
        txd_load   = ld_none;
        shift_1    = 1'b0;
        shift_4    = 1'b0;
        sio_e_set  = '0;
        sio_e_clr  = '0;
        rx_hi      = 1'b0;
        rx_lo      = 1'b0;
        case (state)
            st_startup:
                state_next = st_init;
            //----------------------------------------
            // Enter quad mode, one bit per clock on SIO0
            st_init:
            begin
                seq_inc = 1'b1;
                case (seq)
                    4'd0:
                    begin
                        cs_assert = 1'b1;
                        sck_on    = 1'b1;
                        txd_load  = ld_eqio;
                        sio_e_set = 4'b0001;
                    end
                    4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6:
                        shift_1 = 1'b1;
                    seq_init_last - 4'd1:
                    begin
                        shift_1 = 1'b1;
                        rdy_set = 1'b1;
                    end
                    seq_init_last:
                        frame_end = 1'b1;
                    default:
                        restart = 1'b1;
                endcase
            end
            st_idle:
                seq_inc = 1'b0;
            //----------------------------------------
            // Command and address nibbles are common to both
            st_read, st_write:
            begin
                seq_inc = 1'b1;
                case (seq)
                    4'd0:
                    begin
                        cs_assert = 1'b1;
                        sck_on    = 1'b1;
                        sio_e_set = '1;
                        txd_load  = (state == st_read) ? ld_rdcmd : ld_wrcmd;
                    end
                    4'd1, 4'd3, 4'd5:
                        shift_4 = 1'b1;
                    4'd2:
                        txd_load = ld_addr_hi;
                    4'd4:
                        txd_load = ld_addr_lo;
                    default:
                    begin
                        if (state == st_write)
                        begin
                            case (seq)
                                4'd6:
                                    txd_load = ld_wdata;
                                seq_write_last - 4'd1:
                                begin
                                    shift_4 = 1'b1;
                                    rdy_set = 1'b1;
                                end
                                seq_write_last:
                                    frame_end = 1'b1;
                                default:
                                    restart = 1'b1;
                            endcase
                        end
                        else
                        begin
                            case (seq)
                                // Turnaround, SRAM takes the lines
                                4'd6:
                                    sio_e_clr = '1;
                                4'd7, 4'd8:
                                    seq_inc = 1'b1;
                                seq_read_last - 4'd2:
                                    rx_hi = 1'b1;
                                seq_read_last - 4'd1:
                                begin
                                    rx_lo   = 1'b1;
                                    sck_off = 1'b1;
                                    rdy_set = 1'b1;
                                end
                                seq_read_last:
                                    frame_end = 1'b1;
                                default:
                                    restart = 1'b1;
                            endcase
                        end
                    end
                endcase
            end
            default:
                restart = 1'b1;
        endcase

        // Close the frame and pick up a waiting request
        if (frame_end | restart)
        begin
            seq_inc   = 1'b0;
            cs_negate = 1'b1;
            sck_off   = 1'b1;
            sio_e_clr = '1;
        end
        if (restart)
            state_next = st_startup;
        else if (frame_end | (state == st_idle))
        begin
            state_next = accept_write ? st_write : accept_read ? st_read : st_idle;
            rdy_clr    = accept_write | accept_read;
        end
    end

endmodule

// File: hw/qspi_phy.sv
//----------------------------------------
// QSPI SRAM bridge phy
// Chip select, gated serial clock, transmit
// shifter, line enables and receive byte
//----------------------------------------
`timescale 1ns/1ps

module qspi_phy
(
    input  logic                          CLK,
    input  logic                          RES,
    input  logic                          cs_assert,
    input  logic                          cs_negate,
    input  logic                          sck_on,
    input  logic                          sck_off,
    input  qspi_pkg::txd_load_t           txd_load,
    input  logic                          shift_1,
    input  logic                          shift_4,
    input  logic [qspi_pkg::sio_w-1:0]    sio_e_set,
    input  logic [qspi_pkg::sio_w-1:0]    sio_e_clr,
    input  logic                          rx_hi,
    input  logic                          rx_lo,
    input  logic [qspi_pkg::addr_w-1:0]   addr,
    input  logic [qspi_pkg::data_w-1:0]   wdata,
    output logic [qspi_pkg::data_w-1:0]   rdata,
    output logic                          qspi_cs_n,
    output logic                          qspi_sck,
    output logic [qspi_pkg::sio_w-1:0]    qspi_sio_o,
    output logic [qspi_pkg::sio_w-1:0]    qspi_sio_e,
    input  logic [qspi_pkg::sio_w-1:0]    qspi_sio_i
);
    import qspi_pkg::*;

    logic              sck_en;
    logic              sck_en_neg;
    logic [data_w-1:0] txd;
    logic [sio_w-1:0]  rx_nib;
    logic [data_w-1:0] rx_byte;

    //----------------------------------------
    // Chip select and clock gating
    //----------------------------------------
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            qspi_cs_n <= 1'b1;
        else if (cs_assert)
            qspi_cs_n <= 1'b0;
        else if (cs_negate)
            qspi_cs_n <= 1'b1;
    end

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            sck_en <= 1'b0;
        else if (sck_on)
            sck_en <= 1'b1;
        else if (sck_off)
            sck_en <= 1'b0;
    end

    // Half-cycle delayed copy keeps SCK free of runt pulses
    always_ff @(negedge CLK, posedge RES)
    begin
        if (RES)
            sck_en_neg <= 1'b0;
        else
            sck_en_neg <= sck_en;
    end

    assign qspi_sck = ~CLK & sck_en & sck_en_neg;

    //----------------------------------------
    // Transmit shifter, upper nibble on SIO
    //----------------------------------------
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            txd <= '0;
        else if (shift_1)
            txd <= {txd[data_w-2:0], txd[data_w-1]};
        else if (shift_4)
            txd <= {txd[3:0], txd[data_w-1:4]};
        else
        begin
            case (txd_load)
                // Rotated so bit 7 sits on SIO0 first
                ld_eqio:    txd <= {cmd_eqio[2:0], cmd_eqio[data_w-1:3]};
                ld_rdcmd:   txd <= cmd_read;
                ld_wrcmd:   txd <= cmd_write;
                ld_addr_hi: txd <= addr[addr_w-1:data_w];
                ld_addr_lo: txd <= addr[data_w-1:0];
                ld_wdata:   txd <= wdata;
                default:    txd <= txd;
            endcase
        end
    end

    assign qspi_sio_o = txd[data_w-1:4];

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            qspi_sio_e <= '0;
        else
            qspi_sio_e <= (qspi_sio_e & ~sio_e_clr) | sio_e_set;
    end

    //----------------------------------------
    // Receive, nibble taken on falling edge
    //----------------------------------------
    always_ff @(negedge CLK)
    begin
        if (rx_hi | rx_lo)
            rx_nib <= qspi_sio_i;
    end

    always_ff @(posedge CLK)
    begin
        if (rx_hi)
            rx_byte <= {rx_nib, rx_byte[3:0]};
        else if (rx_lo)
            rx_byte <= {rx_byte[data_w-1:4], rx_nib};
    end

    assign rdata = rx_byte;

endmodule

// File: hw/qspi_sram_top.sv
//----------------------------------------
// QSPI SRAM bridge top level
// Bus port, sequencer and phy
//----------------------------------------
`timescale 1ns/1ps

module qspi_sram_top
(
    input  logic                          CLK,
    input  logic                          RES,
    input  logic                          bus_req,
    input  logic                          bus_write,
    input  logic [qspi_pkg::addr_w-1:0]   bus_addr,
    input  logic [qspi_pkg::data_w-1:0]   bus_wdata,
    output logic [qspi_pkg::data_w-1:0]   bus_rdata,
    output logic                          bus_rdy,
    output logic                          qspi_cs_n,
    output logic                          qspi_sck,
    output logic [qspi_pkg::sio_w-1:0]    qspi_sio_o,
    output logic [qspi_pkg::sio_w-1:0]    qspi_sio_e,
    input  logic [qspi_pkg::sio_w-1:0]    qspi_sio_i
);
    import qspi_pkg::*;

    logic              accept_read;
    logic              accept_write;
    logic              rdy_set;
    logic              rdy_clr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] rdata;
    logic              cs_assert;
    logic              cs_negate;
    logic              sck_on;
    logic              sck_off;
    txd_load_t         txd_load;
    logic              shift_1;
    logic              shift_4;
    logic [sio_w-1:0]  sio_e_set;
    logic [sio_w-1:0]  sio_e_clr;
    logic              rx_hi;
    logic              rx_lo;

    qspi_bus_port i_qspi_bus_port
    (
        .CLK          (CLK),
        .RES          (RES),
        .bus_req      (bus_req),
        .bus_write    (bus_write),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_rdata    (bus_rdata),
        .bus_rdy      (bus_rdy),
        .rdy_set      (rdy_set),
        .rdy_clr      (rdy_clr),
        .rdata        (rdata),
        .accept_read  (accept_read),
        .accept_write (accept_write),
        .addr         (addr),
        .wdata        (wdata)
    );

    qspi_sequencer i_qspi_sequencer
    (
        .CLK          (CLK),
        .RES          (RES),
        .accept_read  (accept_read),
        .accept_write (accept_write),
        .rdy_set      (rdy_set),
        .rdy_clr      (rdy_clr),
        .cs_assert    (cs_assert),
        .cs_negate    (cs_negate),
        .sck_on       (sck_on),
        .sck_off      (sck_off),
        .txd_load     (txd_load),
        .shift_1      (shift_1),
        .shift_4      (shift_4),
        .sio_e_set    (sio_e_set),
        .sio_e_clr    (sio_e_clr),
        .rx_hi        (rx_hi),
        .rx_lo        (rx_lo)
    );

    qspi_phy i_qspi_phy
    (
        .CLK          (CLK),
        .RES          (RES),
        .cs_assert    (cs_assert),
        .cs_negate    (cs_negate),
        .sck_on       (sck_on),
        .sck_off      (sck_off),
        .txd_load     (txd_load),
        .shift_1      (shift_1),
        .shift_4      (shift_4),
        .sio_e_set    (sio_e_set),
        .sio_e_clr    (sio_e_clr),
        .rx_hi        (rx_hi),
        .rx_lo        (rx_lo),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .qspi_cs_n    (qspi_cs_n),
        .qspi_sck     (qspi_sck),
        .qspi_sio_o   (qspi_sio_o),
        .qspi_sio_e   (qspi_sio_e),
        .qspi_sio_i   (qspi_sio_i)
    );

endmodule

// File: testbench/qspi_sram_model.sv
//----------------------------------------
// Behavioral quad SRAM
// Decodes init, read and write frames on
// the SIO lines, 64 KiB memory
//----------------------------------------
`timescale 1ns/1ps

module qspi_sram_model
(
    input  logic       sck,
    input  logic       cs_n,
    input  logic [3:0] sio_in,
    output logic [3:0] sio_out,
    output logic       quad_on,
    output int         frame_count
);

    logic [7:0]  mem [0:65535];
    int          count = 0;
    int          frames = 0;
    logic        quad = 1'b0;
    logic [7:0]  init_byte = 8'h00;
    logic [7:0]  cmd = 8'h00;
    logic [15:0] addr = 16'h0000;
    logic [3:0]  data_hi = 4'h0;
    logic [3:0]  drive_nib = 4'h0;

    initial
    begin
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'hA5;
    end

    // Frame decode, SIO sampled on rising SCK
    always @(posedge sck or posedge cs_n)
    begin
        if (cs_n)
        begin
            if (count != 0)
                frames <= frames + 1;
            count <= 0;
        end
        else
        begin
            count <= count + 1;
            if (!quad)
            begin
                init_byte <= {init_byte[6:0], sio_in[0]};
                if (count == 7 && {init_byte[6:0], sio_in[0]} == 8'h38)
                    quad <= 1'b1;
            end
            else
            begin
                case (count)
                    0, 1:
                        cmd <= {cmd[3:0], sio_in};
                    2, 3, 4, 5:
                        addr <= {addr[11:0], sio_in};
                    6:
                        if (cmd == 8'h02)
                            data_hi <= sio_in;
                    7:
                        if (cmd == 8'h02)
                            mem[addr] <= {data_hi, sio_in};
                    default:
                        ;
                endcase
            end
        end
    end

    // Read data after two turnaround clocks, high nibble first
    always @(negedge sck)
    begin
        if (quad && cmd == 8'h03)
        begin
            if (count == 8)
                drive_nib <= mem[addr][7:4];
            else if (count == 9)
                drive_nib <= mem[addr][3:0];
        end
    end

    assign sio_out     = drive_nib;
    assign quad_on     = quad;
    assign frame_count = frames;

endmodule

// File: testbench/qspi_sram_properties.sv
//----------------------------------------
// QSPI SRAM bridge properties
// Idle SRAM lines and ready handshake
//----------------------------------------
`timescale 1ns/1ps

module qspi_sram_properties
(
    input logic       CLK,
    input logic       RES,
    input logic       bus_req,
    input logic       bus_rdy,
    input logic       qspi_cs_n,
    input logic       qspi_sck,
    input logic [3:0] qspi_sio_e
);

    // Failed assertions seen so far
    int fail_count = 0;

    // Lines released while deselected
    sio_e_idle: assert property (@(posedge CLK) disable iff (RES)
        qspi_cs_n |-> (qspi_sio_e == 4'b0000))
    else
    begin
        fail_count++;
        $error("SIO enables active while qspi_cs_n is high");
    end

    sck_idle: assert property (@(posedge CLK) disable iff (RES)
        qspi_cs_n |-> !qspi_sck)
    else
    begin
        fail_count++;
        $error("qspi_sck active while qspi_cs_n is high");
    end

    // Ready drops right after acceptance
    rdy_drop: assert property (@(posedge CLK) disable iff (RES)
        (bus_req && bus_rdy) |=> !bus_rdy)
    else
    begin
        fail_count++;
        $error("bus_rdy still high after acceptance");
    end

endmodule

bind qspi_sram_top qspi_sram_properties i_qspi_sram_properties
(
    .CLK        (CLK),
    .RES        (RES),
    .bus_req    (bus_req),
    .bus_rdy    (bus_rdy),
    .qspi_cs_n  (qspi_cs_n),
    .qspi_sck   (qspi_sck),
    .qspi_sio_e (qspi_sio_e)
);

// File: testbench/qspi_sram_tb.sv
//----------------------------------------
// QSPI SRAM bridge testbench
// Table of reads and writes against the
// quad SRAM model, latency and CS checks
//----------------------------------------
`timescale 1ns/1ps

module qspi_sram_tb;
    import qspi_pkg::*;

    localparam int n_entries   = 12;
    localparam int rdy_timeout = 64;
    localparam int cs_timeout  = 2;
    localparam int hold_cycles = 3;
    localparam int write_lat   = 8;
    localparam int read_lat    = 11;

    logic              CLK;
    logic              RES;
    logic              bus_req;
    logic              bus_write;
    logic [addr_w-1:0] bus_addr;
    logic [data_w-1:0] bus_wdata;
    logic [data_w-1:0] bus_rdata;
    logic              bus_rdy;
    logic              qspi_cs_n;
    logic              qspi_sck;
    logic [sio_w-1:0]  qspi_sio_o;
    logic [sio_w-1:0]  qspi_sio_e;
    logic [sio_w-1:0]  qspi_sio_i;
    logic [sio_w-1:0]  sio_lines;
    logic              quad_on;
    int                frame_count;

    // Stimulus table
    logic              tbl_write [n_entries];
    logic [addr_w-1:0] tbl_addr  [n_entries];
    logic [data_w-1:0] tbl_wdata [n_entries];
    logic [data_w-1:0] tbl_rdata [n_entries];
    logic [data_w-1:0] shadow [int];

    integer seed = 50845;
    int     check_count = 0;
    int     error_count = 0;
    int     timeout_count = 0;
    logic   aborted = 1'b0;

    qspi_sram_top i_qspi_sram_top
    (
        .CLK        (CLK),
        .RES        (RES),
        .bus_req    (bus_req),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_rdy    (bus_rdy),
        .qspi_cs_n  (qspi_cs_n),
        .qspi_sck   (qspi_sck),
        .qspi_sio_o (qspi_sio_o),
        .qspi_sio_e (qspi_sio_e),
        .qspi_sio_i (qspi_sio_i)
    );

    assign sio_lines = qspi_sio_o & qspi_sio_e;

    qspi_sram_model i_qspi_sram_model
    (
        .sck         (qspi_sck),
        .cs_n        (qspi_cs_n),
        .sio_in      (sio_lines),
        .sio_out     (qspi_sio_i),
        .quad_on     (quad_on),
        .frame_count (frame_count)
    );

    always #2 CLK = ~CLK;

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task report_timeout(input string what);
        timeout_count++;
        aborted = 1'b1;
        $display("Timeout at t=%0t: %s did not happen in time", $time, what);
    endtask

    // Expected read data follows the shadow memory, 0xA5 when unwritten
    task set_entry(input int i, input logic wr, input logic [15:0] a, input logic [7:0] d);
        tbl_write[i] = wr;
        tbl_addr[i]  = a;
        tbl_wdata[i] = d;
        if (wr)
            shadow[int'(a)] = d;
        tbl_rdata[i] = shadow.exists(int'(a)) ? shadow[int'(a)] : 8'hA5;
    endtask

    task build_table;
        logic [31:0] r;
        logic [15:0] a_rand;
        logic [15:0] a_rand2;
        r = $random(seed);
        a_rand = r[15:0];
        while (a_rand == 16'h0000 || a_rand == 16'hFFFF || a_rand == 16'h1234 ||
               a_rand == 16'h4321)
            a_rand = a_rand + 16'h0101;
        r = $random(seed);
        a_rand2 = r[15:0];
        while (a_rand2 == a_rand || a_rand2 == 16'h0000 || a_rand2 == 16'hFFFF ||
               a_rand2 == 16'h1234 || a_rand2 == 16'h4321)
            a_rand2 = a_rand2 + 16'h0101;
        set_entry(0, 1'b1, 16'h1234, 8'h5A);
        set_entry(1, 1'b0, 16'h1234, 8'h00);
        r = $random(seed);
        set_entry(2, 1'b1, 16'h0000, r[7:0]);
        set_entry(3, 1'b1, 16'hFFFF, r[15:8]);
        set_entry(4, 1'b1, a_rand, r[23:16]);
        set_entry(5, 1'b0, 16'h0000, 8'h00);
        set_entry(6, 1'b0, 16'hFFFF, 8'h00);
        set_entry(7, 1'b0, a_rand, 8'h00);
        set_entry(8, 1'b0, 16'h4321, 8'h00);
        set_entry(9, 1'b1, a_rand2, r[31:24]);
        set_entry(10, 1'b0, a_rand2, 8'h00);
        set_entry(11, 1'b0, 16'h1234, 8'h00);
    endtask

    // Counts falling edges until bus_rdy is high, drops the request after a hold
    task wait_rdy(output int cycles);
        cycles = 0;
        do
        begin
            @(negedge CLK);
            cycles++;
            if (cycles == hold_cycles)
                bus_req = 1'b0;
            if (cycles > rdy_timeout)
            begin
                report_timeout("bus_rdy rising");
                return;
            end
        end
        while (!bus_rdy);
    endtask

    task wait_cs_high;
        int n;
        n = 0;
        while (!qspi_cs_n)
        begin
            if (n == cs_timeout)
            begin
                report_timeout("qspi_cs_n rising after bus_rdy");
                return;
            end
            @(negedge CLK);
            n++;
        end
    endtask

    task apply_entry(input int i);
        int cycles;
        bus_req   = 1'b1;
        bus_write = tbl_write[i];
        bus_addr  = tbl_addr[i];
        bus_wdata = tbl_wdata[i];
        wait_rdy(cycles);
        if (aborted)
            return;
        // Count includes the falling edge after bus_rdy rises
        check_value("latency", 32'(cycles - 1), tbl_write[i] ? write_lat : read_lat);
        if (!tbl_write[i])
            check_value("bus_rdata", 32'(bus_rdata), 32'(tbl_rdata[i]));
        wait_cs_high();
    endtask

    initial
    begin
        int cycles;
        int assert_fails;
        CLK       = 1'b0;
        RES       = 1'b1;
        bus_req   = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        build_table();
        repeat (8) @(posedge CLK);
        @(negedge CLK);

        // Idle SRAM side and bus while in reset
        check_value("bus_rdy", 32'(bus_rdy), 32'd0);
        check_value("qspi_cs_n", 32'(qspi_cs_n), 32'd1);
        check_value("qspi_sio_e", 32'(qspi_sio_e), 32'd0);
        check_value("qspi_sck", 32'(qspi_sck), 32'd0);
        RES = 1'b0;

        // Init frame puts the SRAM in quad mode
        wait_rdy(cycles);
        if (!aborted)
            wait_cs_high();
        if (!aborted)
            check_value("quad_on", 32'(quad_on), 32'd1);

        for (int i = 0; i < n_entries && !aborted; i++)
            apply_entry(i);
        if (!aborted)
            check_value("frame_count", 32'(frame_count), 32'(n_entries + 1));

        assert_fails = i_qspi_sram_top.i_qspi_sram_properties.fail_count;
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 check_count, error_count, timeout_count, assert_fails);
        if (error_count == 0 && timeout_count == 0 && assert_fails == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: src.f
hw/qspi_pkg.sv
hw/qspi_bus_port.sv
hw/qspi_sequencer.sv
hw/qspi_phy.sv
hw/qspi_sram_top.sv
testbench/qspi_sram_model.sv
testbench/qspi_sram_properties.sv
testbench/qspi_sram_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module qspi_sram_tb -Mdir obj_dir -f src.f
	./obj_dir/Vqspi_sram_tb | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
